// File: src/cam_cfg_settings.svh
`ifndef CAM_CFG_SETTINGS_SVH
`define CAM_CFG_SETTINGS_SVH

// clock rates, 40 sys_clk per serial bit
`define CAM_SYS_CLK_HZ   10_000_000
`define CAM_SCL_HZ       250_000

// 7-bit sensor address, r/w bit appended by the master
`define CAM_DEV_ADDR     7'h3C

// entries in the register table
`define CAM_TABLE_DEPTH  6

`endif

// File: src/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    typedef enum logic {
        BUS_WRITE,
        BUS_READ
    } bus_op_t;

    // one register access, start to stop
    typedef enum logic [3:0] {
        PH_IDLE, PH_START, PH_DEV_ADDR, PH_ACK,
        PH_ADDR_HI, PH_ADDR_LO, PH_WDATA, PH_RSTART,
        PH_RD_ADDR, PH_RDATA, PH_NACK, PH_STOP
    } master_phase_t;

endpackage

`default_nettype wire

// File: src/cam_cfg_pkg.sv
`default_nettype none

package cam_cfg_pkg;

    typedef enum logic {
        KIND_SET,     // write value
        KIND_CHECK    // read back, compare with value
    } entry_kind_t;

    // one line of the sensor register table
    typedef struct packed {
        entry_kind_t  kind;
        logic [15:0]  reg_addr;
        logic [7:0]   value;
    } cfg_entry_t;

endpackage

`default_nettype wire

// File: src/i2c_scl_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_cfg_settings.svh"

module i2c_scl_gen (
    input  wire   sys_clk,
    input  wire   sys_rst_n,
    output logic  scl,
    output logic  scl_hi_mid,
    output logic  scl_lo_mid
);

    localparam int DIV   = `CAM_SYS_CLK_HZ / `CAM_SCL_HZ;
    localparam int CNT_W = $clog2(DIV);

    logic [CNT_W-1:0] div_cnt;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt    <= '0;
            scl        <= 1'b1;   // bus idles high
            scl_hi_mid <= 1'b0;
            scl_lo_mid <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == CNT_W'(DIV - 1)) ? '0 : div_cnt + 1'b1;

            if (div_cnt == CNT_W'(DIV / 2 - 1))
                scl <= 1'b0;
            else if (div_cnt == CNT_W'(DIV - 1))
                scl <= 1'b1;

            // quarter points land mid high and mid low
            scl_hi_mid <= (div_cnt == CNT_W'(DIV / 4));
            scl_lo_mid <= (div_cnt == CNT_W'(DIV / 2 + DIV / 4));
        end
    end

endmodule

`default_nettype wire

// File: src/i2c_reg_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_cfg_settings.svh"

module i2c_reg_master
    import i2c_bus_pkg::*;
(
    input  wire           sys_clk,
    input  wire           sys_rst_n,
    input  wire           scl_hi_mid,
    input  wire           scl_lo_mid,
    input  wire           cmd_valid,
    input  wire bus_op_t  cmd_op,
    input  wire  [15:0]   cmd_addr,
    input  wire  [7:0]    cmd_wdata,
    inout  wire           sda,
    output logic          master_busy,
    output logic          xfer_done,
    output logic          xfer_nack,
    output logic [7:0]    rdata
);

    localparam logic [7:0] ADDR_WR = {`CAM_DEV_ADDR, 1'b0};
    localparam logic [7:0] ADDR_RD = {`CAM_DEV_ADDR, 1'b1};

    master_phase_t phase;
    master_phase_t ack_next;   // where to go once the slave acks

    logic          sda_low;    // open drain, only ever pulls low
    logic [7:0]    shift;
    logic [3:0]    bit_cnt;
    logic          nack_r;

    bus_op_t       op_r;
    logic [15:0]   addr_r;
    logic [7:0]    wdata_r;

    assign sda         = sda_low ? 1'b0 : 1'bz;
    assign master_busy = (phase != PH_IDLE);

    ////////////////////
    // command capture
    ////////////////////

    always_ff @(posedge sys_clk) begin
        if (cmd_valid && phase == PH_IDLE) begin
            op_r    <= cmd_op;
            addr_r  <= cmd_addr;
            wdata_r <= cmd_wdata;
        end
    end

    ////////////////////
    // phase machine
    ////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            phase     <= PH_IDLE;
            ack_next  <= PH_IDLE;
            sda_low   <= 1'b0;
            shift     <= '0;
            bit_cnt   <= '0;
            nack_r    <= 1'b0;
            xfer_done <= 1'b0;
            xfer_nack <= 1'b0;
            rdata     <= '0;
        end else begin
            xfer_done <= 1'b0;

            case (phase)
                PH_IDLE: begin
                    sda_low <= 1'b0;
                    if (cmd_valid) begin
                        nack_r <= 1'b0;
                        phase  <= PH_START;
                    end
                end

                PH_START: begin
                    if (scl_hi_mid) begin
                        sda_low  <= 1'b1;          // sda falls with scl high
                        shift    <= ADDR_WR;
                        bit_cnt  <= 4'd8;
                        ack_next <= PH_ADDR_HI;
                        phase    <= PH_DEV_ADDR;
                    end
                end

                // every outgoing byte shares this path
                PH_DEV_ADDR, PH_ADDR_HI, PH_ADDR_LO, PH_WDATA, PH_RD_ADDR: begin
                    if (scl_lo_mid) begin
                        if (bit_cnt != 4'd0) begin
                            sda_low <= ~shift[7];  // msb first
                            shift   <= {shift[6:0], 1'b0};
                            bit_cnt <= bit_cnt - 1'b1;
                        end else begin
                            sda_low <= 1'b0;       // hand sda over for ack
                            phase   <= PH_ACK;
                        end
                    end
                end

                PH_ACK: begin
                    if (scl_hi_mid) begin
                        if (sda) begin
                            nack_r <= 1'b1;        // no ack, abort
                            phase  <= PH_STOP;
                        end else begin
                            bit_cnt <= 4'd8;
                            phase   <= ack_next;
                            case (ack_next)
                                PH_ADDR_HI: begin
                                    shift    <= addr_r[15:8];
                                    ack_next <= PH_ADDR_LO;
                                end
                                PH_ADDR_LO: begin
                                    shift    <= addr_r[7:0];
                                    ack_next <= (op_r == BUS_READ) ? PH_RSTART : PH_WDATA;
                                end
                                PH_WDATA: begin
                                    shift    <= wdata_r;
                                    ack_next <= PH_STOP;
                                end
                                default: ;                 // stop, restart, read data
                            endcase
                        end
                    end
                end

                PH_RSTART: begin
                    if (scl_hi_mid) begin
                        sda_low  <= 1'b1;          // repeated start
                        shift    <= ADDR_RD;
                        bit_cnt  <= 4'd8;
                        ack_next <= PH_RDATA;
                        phase    <= PH_RD_ADDR;
                    end
                end

                PH_RDATA: begin
                    if (scl_hi_mid && bit_cnt != 4'd0) begin
                        shift   <= {shift[6:0], sda};
                        bit_cnt <= bit_cnt - 1'b1;
                    end else if (scl_lo_mid && bit_cnt == 4'd0) begin
                        rdata <= shift;
                        phase <= PH_NACK;          // sda stays released
                    end
                end

                PH_NACK: begin
                    if (scl_hi_mid)
                        phase <= PH_STOP;
                end

                PH_STOP: begin
                    if (scl_lo_mid) begin
                        sda_low <= 1'b1;
                    end else if (scl_hi_mid && sda_low) begin
                        sda_low   <= 1'b0;         // sda rises with scl high
                        xfer_done <= 1'b1;
                        xfer_nack <= nack_r;
                        phase     <= PH_IDLE;
                    end
                end

                default: begin
                    sda_low <= 1'b0;
                    phase   <= PH_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/cam_cfg_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_cfg_settings.svh"

module cam_cfg_sequencer
    import i2c_bus_pkg::*, cam_cfg_pkg::*;
(
    input  wire           sys_clk,
    input  wire           sys_rst_n,
    input  wire           cfg_start,
    input  wire           xfer_done,
    input  wire           xfer_nack,
    output logic          cmd_valid,
    output bus_op_t       cmd_op,
    output logic [15:0]   cmd_addr,
    output logic [7:0]    cmd_wdata,
    output logic          check_en,
    output logic [7:0]    check_value,
    output logic          seq_start,
    output logic          seq_end,
    output logic          cfg_busy
);

    localparam int IDX_W = $clog2(`CAM_TABLE_DEPTH);
    localparam int LAST  = `CAM_TABLE_DEPTH - 1;

    logic [IDX_W-1:0] idx;
    logic             issue_pend;
    cfg_entry_t       entry;

    ////////////////////
    // register table
    ////////////////////

    always_comb begin
        case (idx)
            3'd0:    entry = '{KIND_SET,   16'h3008, 8'h82};   // soft reset
            3'd1:    entry = '{KIND_SET,   16'h3103, 8'h03};
            3'd2:    entry = '{KIND_SET,   16'h3017, 8'hFF};   // pad enables
            3'd3:    entry = '{KIND_SET,   16'h3018, 8'hFF};
            3'd4:    entry = '{KIND_CHECK, 16'h3103, 8'h03};
            3'd5:    entry = '{KIND_CHECK, 16'h300A, 8'h56};   // chip id
            default: entry = '{KIND_SET,   16'h0000, 8'h00};
        endcase
    end

    assign cmd_op      = (entry.kind == KIND_CHECK) ? BUS_READ : BUS_WRITE;
    assign cmd_addr    = entry.reg_addr;
    assign cmd_wdata   = entry.value;
    assign check_en    = cfg_busy && (entry.kind == KIND_CHECK);
    assign check_value = entry.value;

    ////////////////////
    // run control
    ////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            idx        <= '0;
            issue_pend <= 1'b0;
            cmd_valid  <= 1'b0;
            seq_start  <= 1'b0;
            seq_end    <= 1'b0;
            cfg_busy   <= 1'b0;
        end else begin
            seq_start  <= 1'b0;
            seq_end    <= 1'b0;
            cmd_valid  <= issue_pend;   // one cycle behind the request
            issue_pend <= 1'b0;

            if (cfg_start && !cfg_busy) begin
                cfg_busy   <= 1'b1;
                idx        <= '0;
                seq_start  <= 1'b1;
                issue_pend <= 1'b1;
            end else if (cfg_busy && xfer_done) begin
                if (xfer_nack || idx == IDX_W'(LAST)) begin
                    cfg_busy <= 1'b0;     // finished or aborted
                    seq_end  <= 1'b1;
                end else begin
                    idx        <= idx + 1'b1;
                    issue_pend <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/cam_cfg_verify.sv
`timescale 1ns/100ps
`default_nettype none

module cam_cfg_verify (
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         seq_start,
    input  wire         seq_end,
    input  wire         xfer_done,
    input  wire         xfer_nack,
    input  wire         check_en,
    input  wire  [7:0]  check_value,
    input  wire  [7:0]  rdata,
    output logic [2:0]  mismatch_count,
    output logic        nack_seen,
    output logic        cfg_error,
    output logic        cfg_done
);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            mismatch_count <= '0;
            nack_seen      <= 1'b0;
            cfg_error      <= 1'b0;
            cfg_done       <= 1'b0;
        end else begin
            cfg_done <= seq_end;

            if (seq_start) begin
                mismatch_count <= '0;   // fresh status per run
                nack_seen      <= 1'b0;
                cfg_error      <= 1'b0;
            end else if (xfer_done) begin
                if (xfer_nack)
                    nack_seen <= 1'b1;
                else if (check_en && rdata != check_value && mismatch_count != 3'd7)
                    mismatch_count <= mismatch_count + 1'b1;   // saturates
            end

            if (seq_end)
                cfg_error <= (mismatch_count != '0) || nack_seen;
        end
    end

endmodule

`default_nettype wire

// File: src/cam_cfg_top.sv
`timescale 1ns/100ps
`default_nettype none

module cam_cfg_top
    import i2c_bus_pkg::*;
(
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         cfg_start,
    output logic        scl,
    inout  wire         sda,
    output logic        cfg_busy,
    output logic        cfg_done,
    output logic        cfg_error,
    output logic        nack_seen,
    output logic [2:0]  mismatch_count
);

    logic        scl_hi_mid;
    logic        scl_lo_mid;
    logic        cmd_valid;
    bus_op_t     cmd_op;
    logic [15:0] cmd_addr;
    logic [7:0]  cmd_wdata;
    logic        xfer_done;
    logic        xfer_nack;
    logic [7:0]  rdata;
    logic        check_en;
    logic [7:0]  check_value;
    logic        seq_start;
    logic        seq_end;

    i2c_scl_gen u_scl_gen (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .scl        (scl),
        .scl_hi_mid (scl_hi_mid),
        .scl_lo_mid (scl_lo_mid)
    );

    cam_cfg_sequencer u_sequencer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .cfg_start   (cfg_start),
        .xfer_done   (xfer_done),
        .xfer_nack   (xfer_nack),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .check_en    (check_en),
        .check_value (check_value),
        .seq_start   (seq_start),
        .seq_end     (seq_end),
        .cfg_busy    (cfg_busy)
    );

    i2c_reg_master u_master (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .scl_hi_mid  (scl_hi_mid),
        .scl_lo_mid  (scl_lo_mid),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .sda         (sda),
        .master_busy (),
        .xfer_done   (xfer_done),
        .xfer_nack   (xfer_nack),
        .rdata       (rdata)
    );

    cam_cfg_verify u_verify (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .seq_start      (seq_start),
        .seq_end        (seq_end),
        .xfer_done      (xfer_done),
        .xfer_nack      (xfer_nack),
        .check_en       (check_en),
        .check_value    (check_value),
        .rdata          (rdata),
        .mismatch_count (mismatch_count),
        .nack_seen      (nack_seen),
        .cfg_error      (cfg_error),
        .cfg_done       (cfg_done)
    );

endmodule

`default_nettype wire

// File: tb/i2c_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_cfg_settings.svh"

module i2c_slave_model (
    input  wire  scl,
    inout  wire  sda
);

    localparam logic [15:0] CHIP_ID_ADDR = 16'h300A;

    typedef enum {
        S_IDLE, S_DEV, S_REG_HI, S_REG_LO, S_WDATA, S_RDATA, S_DONE
    } slave_phase_t;

    logic [7:0]   mem     [0:65535];   // sensor registers
    logic         written [0:65535];   // set by bus writes only
    slave_phase_t phase;
    logic         drive_low;
    logic         scl_q;
    logic         sda_q;
    logic [7:0]   shift_in;
    logic [7:0]   tx_byte;
    logic         tx_active;
    logic [15:0]  ptr;
    int           bit_pos;             // scl rises seen in this byte frame
    int           txn_count;
    int           nack_at_entry;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        phase         = S_IDLE;
        drive_low     = 1'b0;
        scl_q         = 1'b1;
        sda_q         = 1'b1;
        shift_in      = '0;
        tx_byte       = '0;
        tx_active     = 1'b0;
        ptr           = '0;
        bit_pos       = 0;
        txn_count     = 0;
        nack_at_entry = 0;
    end

    // clears the memory and loads the controls for the next run
    task reset_model(input logic [7:0] id, input int nack_entry);
        for (int a = 0; a < 65536; a++) begin
            mem[a]     = a[15:8] ^ a[7:0];
            written[a] = 1'b0;
        end
        mem[CHIP_ID_ADDR] = id;
        nack_at_entry     = nack_entry;   // 0 means always ack
        txn_count         = 0;
        phase             = S_IDLE;
        drive_low         = 1'b0;
        bit_pos           = 0;
    endtask

    // acts on a complete received byte, ack by pulling sda
    task take_byte();
        case (phase)
            S_DEV: begin
                if (shift_in[7:1] != `CAM_DEV_ADDR) begin
                    phase = S_IDLE;
                end else if (shift_in[0]) begin
                    tx_byte   = mem[ptr];
                    phase     = S_RDATA;
                    drive_low = 1'b1;
                end else begin
                    txn_count = txn_count + 1;
                    if (txn_count == nack_at_entry) begin
                        phase = S_IDLE;           // refuse this transaction
                    end else begin
                        phase     = S_REG_HI;
                        drive_low = 1'b1;
                    end
                end
            end
            S_REG_HI: begin
                ptr[15:8] = shift_in;
                phase     = S_REG_LO;
                drive_low = 1'b1;
            end
            S_REG_LO: begin
                ptr[7:0]  = shift_in;
                phase     = S_WDATA;            // or a repeated start follows
                drive_low = 1'b1;
            end
            S_WDATA: begin
                mem[ptr]     = shift_in;
                written[ptr] = 1'b1;
                phase        = S_DONE;          // single data byte only
                drive_low    = 1'b1;
            end
            default: ;
        endcase
    endtask

    task scl_rise();
        if (phase != S_IDLE) begin
            if (bit_pos < 8 && phase != S_RDATA)
                shift_in = {shift_in[6:0], (sda === 1'b1)};
            bit_pos = bit_pos + 1;
        end
    endtask

    task scl_fall();
        if (phase != S_IDLE) begin
            if (bit_pos == 8) begin
                if (phase == S_RDATA)
                    drive_low = 1'b0;           // master sends the nack
                else if (phase != S_DONE)
                    take_byte();
            end else if (bit_pos == 9) begin
                bit_pos   = 0;
                drive_low = 1'b0;
                if (phase == S_RDATA) begin
                    if (tx_active) begin
                        phase = S_DONE;
                    end else begin
                        tx_active = 1'b1;
                        drive_low = ~tx_byte[7];
                    end
                end
            end else if (phase == S_RDATA && tx_active && bit_pos >= 1) begin
                drive_low = ~tx_byte[7 - bit_pos];
            end
        end
    endtask

    ////////////////////
    // bus watcher
    ////////////////////

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q) begin
            if (sda === 1'b0) begin
                phase     = S_DEV;   // start or repeated start
                bit_pos   = 0;
                tx_active = 1'b0;
            end else if (sda === 1'b1) begin
                phase     = S_IDLE;  // stop
                drive_low = 1'b0;
            end
        end else if (scl === 1'b1 && scl_q === 1'b0) begin
            scl_rise();
        end else if (scl === 1'b0 && scl_q === 1'b1) begin
            scl_fall();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

// File: tb/tb_cam_cfg.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_cfg_settings.svh"

module tb_cam_cfg;

    localparam int NUM_ROWS    = 4;
    localparam int NUM_SETS    = 4;
    localparam int BIT_CYCLES  = `CAM_SYS_CLK_HZ / `CAM_SCL_HZ;
    localparam int RUN_CYCLES  = `CAM_TABLE_DEPTH * 40 * BIT_CYCLES * 2;
    localparam int WATCHDOG_NS = NUM_ROWS * RUN_CYCLES * 100;

    typedef struct packed {
        logic [7:0] chip_id;
        logic [3:0] nack_at;
        logic [2:0] exp_mismatch;
        logic       exp_nack;
        logic       exp_error;
    } scenario_t;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        cfg_start;
    wire         scl;
    wire         sda;
    wire         cfg_busy;
    wire         cfg_done;
    wire         cfg_error;
    wire         nack_seen;
    wire  [2:0]  mismatch_count;
    int          err_count;

    scenario_t   rows      [0:NUM_ROWS-1];
    logic [15:0] set_addr  [0:NUM_SETS-1];
    logic [7:0]  set_value [0:NUM_SETS-1];

    pullup (sda);   // open-drain bus

    cam_cfg_top dut (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .cfg_start      (cfg_start),
        .scl            (scl),
        .sda            (sda),
        .cfg_busy       (cfg_busy),
        .cfg_done       (cfg_done),
        .cfg_error      (cfg_error),
        .nack_seen      (nack_seen),
        .mismatch_count (mismatch_count)
    );

    i2c_slave_model slave (
        .scl (scl),
        .sda (sda)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    task load_tables();
        rows[0] = {8'h56, 4'd0, 3'd0, 1'b0, 1'b0};   // clean run
        rows[1] = {8'h00, 4'd0, 3'd1, 1'b0, 1'b1};   // wrong chip id
        rows[2] = {8'h56, 4'd3, 3'd0, 1'b1, 1'b1};   // address nack on entry 3
        rows[3] = {8'h56, 4'd0, 3'd0, 1'b0, 1'b0};   // rerun after a failure
        set_addr[0] = 16'h3008;
        set_value[0] = 8'h82;
        set_addr[1] = 16'h3103;
        set_value[1] = 8'h03;
        set_addr[2] = 16'h3017;
        set_value[2] = 8'hFF;
        set_addr[3] = 16'h3018;
        set_value[3] = 8'hFF;
    endtask

    task abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task report_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        err_count = err_count + 1;
        $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        abort_run();
    endtask

    task check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else report_value(name, got, exp);
    endtask

    task step_clock();
        @(posedge sys_clk);
        #10;
    endtask

    task pulse_start();
        cfg_start = 1'b1;
        step_clock();
        cfg_start = 1'b0;
    endtask

    task automatic wait_done(input int r);
        int n;
        n = 0;
        while (cfg_done !== 1'b1 && n < RUN_CYCLES) begin
            step_clock();
            n = n + 1;
        end
        assert (cfg_done === 1'b1) else begin
            err_count = err_count + 1;
            $display("row %0d: cfg_done did not arrive within %0d cycles", r, RUN_CYCLES);
            abort_run();
        end
    endtask

    // set entries before the refused one must have landed
    task automatic check_memory(input int nack_at);
        for (int i = 0; i < NUM_SETS; i++) begin
            if (nack_at == 0 || i + 1 < nack_at) begin
                check_value($sformatf("slave.written[%h]", set_addr[i]),
                            slave.written[set_addr[i]], 1'b1);
                check_value($sformatf("slave.mem[%h]", set_addr[i]),
                            slave.mem[set_addr[i]], set_value[i]);
            end else begin
                check_value($sformatf("slave.written[%h]", set_addr[i]),
                            slave.written[set_addr[i]], 1'b0);
            end
        end
    endtask

    task automatic run_row(input int r);
        scenario_t row;
        row = rows[r];
        slave.reset_model(row.chip_id, row.nack_at);
        pulse_start();
        check_value("cfg_busy", cfg_busy, 1'b1);
        wait_done(r);
        check_value("mismatch_count", mismatch_count, row.exp_mismatch);
        check_value("nack_seen", nack_seen, row.exp_nack);
        check_value("cfg_error", cfg_error, row.exp_error);
        check_value("cfg_busy", cfg_busy, 1'b0);
        check_memory(row.nack_at);
        step_clock();
        check_value("cfg_done", cfg_done, 1'b0);   // single pulse
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        sys_rst_n = 1'b0;
        cfg_start = 1'b0;
        err_count = 0;
        load_tables();
        repeat (2) @(posedge sys_clk);
        #10;
        sys_rst_n = 1'b1;
        step_clock();

        // idle state straight out of reset
        check_value("cfg_busy", cfg_busy, 1'b0);
        check_value("cfg_done", cfg_done, 1'b0);
        check_value("cfg_error", cfg_error, 1'b0);
        check_value("nack_seen", nack_seen, 1'b0);
        check_value("mismatch_count", mismatch_count, 3'd0);
        check_value("scl", scl, 1'b1);
        check_value("sda", sda, 1'b1);

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout: the run took longer than %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/i2c_bus_pkg.sv
src/cam_cfg_pkg.sv
src/i2c_scl_gen.sv
src/i2c_reg_master.sv
src/cam_cfg_sequencer.sv
src/cam_cfg_verify.sv
src/cam_cfg_top.sv
tb/i2c_slave_model.sv
tb/tb_cam_cfg.sv
